//--- dv/dcache_testdata.txt
# Columns: op (LB LH LW LBU LHU SB SH SW), byte address, write data, expected load data, kind.
# All values are hex; kind is hit, miss or store; expected data of a store is unused.
LW  00000100 00000000 00000000 miss
SW  00000100 8c7ff180 00000000 store
SW  00000104 12345678 00000000 store
LW  00000100 00000000 8c7ff180 miss
LW  00000100 00000000 8c7ff180 hit
LW  00000104 00000000 12345678 miss
LB  00000100 00000000 ffffff80 hit
LB  00000101 00000000 fffffff1 hit
LB  00000102 00000000 0000007f hit
LB  00000103 00000000 ffffff8c hit
LBU 00000100 00000000 00000080 hit
LBU 00000101 00000000 000000f1 hit
LBU 00000102 00000000 0000007f hit
LBU 00000103 00000000 0000008c hit
LH  00000100 00000000 fffff180 hit
LH  00000101 00000000 00007ff1 hit
LH  00000102 00000000 ffff8c7f hit
LH  00000103 00000000 ffff8c7f hit
LHU 00000101 00000000 00007ff1 hit
LHU 00000103 00000000 00008c7f hit
SB  00000105 000000ab 00000000 store
SH  00000106 0000cdef 00000000 store
SH  00000105 00003c4d 00000000 store
LW  00000104 00000000 cd3c4d78 miss
LHU 00000105 00000000 00003c4d hit
SW  00000140 deadbeef 00000000 store
LW  00000100 00000000 8c7ff180 miss
LW  00000140 00000000 deadbeef miss
LW  00000100 00000000 8c7ff180 miss

//--- tb.f
+incdir+include
src/memOpPkg.sv
src/cacheTypesPkg.sv
src/storeMerge.sv
src/loadAligner.sv
src/backingMemory.sv
src/cacheArray.sv
src/cacheController.sv
src/dataMemorySubsystem.sv
dv/clockGen.sv
dv/dataMemoryTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module dataMemoryTb --Mdir build -o simv
./build/simv | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed."
    exit 1
fi
echo "Simulation passed."

//--- dv/dataMemoryTb.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dataMemoryTb
    import memOpPkg::*;
();
    typedef enum logic [1:0] {
        KIND_HIT,
        KIND_MISS,
        KIND_STORE
    } kind_e;

    // One line of the vector file.
    typedef struct packed {
        memReq_t                req;
        logic [`DATA_WIDTH-1:0] expData;
        kind_e                  kind;
    } vector_t;

    localparam int ResetCycles = 8;
    localparam int MissCycles  = `MEM_LATENCY + 2;

    logic                   iClk;
    logic                   arstN;
    logic                   req;
    memReq_t                reqData;
    logic                   busy;
    logic                   readValid;
    logic [`DATA_WIDTH-1:0] readData;
    logic                   storeDone;

    vector_t vectors [$];
    int      errors;
    int      checks;
    int      cycleCount;
    int      cycleLimit;

    clockGen u_clockGen (.iClk(iClk));

    dataMemorySubsystem u_dataMemorySubsystem (
        .iClk(iClk), .arstN(arstN), .req(req), .reqData(reqData), .busy(busy),
        .readValid(readValid), .readData(readData), .storeDone(storeDone)
    );

    function automatic logic decodeOp(input string name, output memOp_e op);
        op = LOAD_WORD;
        case (name)
            "LB":    op = LOAD_BYTE;
            "LH":    op = LOAD_HALF;
            "LW":    op = LOAD_WORD;
            "LBU":   op = ULOAD_BYTE;
            "LHU":   op = ULOAD_HALF;
            "SB":    op = STORE_BYTE;
            "SH":    op = STORE_HALF;
            "SW":    op = STORE_WORD;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    function automatic logic decodeKind(input string name, output kind_e kind);
        kind = KIND_HIT;
        case (name)
            "hit":   kind = KIND_HIT;
            "miss":  kind = KIND_MISS;
            "store": kind = KIND_STORE;
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    task automatic readVectors();
        int                     fd;
        int                     n;
        string                  line;
        string                  opName;
        string                  kindName;
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
        logic [`DATA_WIDTH-1:0] expData;
        memOp_e                 op;
        kind_e                  kind;
        vector_t                v;
        fd = $fopen("dv/dcache_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file dv/dcache_testdata.txt.");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") continue; // Column notes.
            n = $sscanf(line, "%s %h %h %h %s", opName, addr, wdata, expData, kindName);
            if (n <= 0) continue;
            if (n != 5 || !decodeOp(opName, op) || !decodeKind(kindName, kind)) begin
                $display("Malformed vector line skipped: %s", line);
                errors++;
                continue;
            end
            v.req.op    = op;
            v.req.addr  = addr;
            v.req.wdata = wdata;
            v.expData   = expData;
            v.kind      = kind;
            vectors.push_back(v);
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("No test vectors were read.");
            errors++;
        end
    endtask

    task automatic checkIdle(input string when);
        checks++;
        if (busy !== 1'b0 || readValid !== 1'b0 || storeDone !== 1'b0) begin
            $display("FAILED at %0t: busy, readValid or storeDone high %s", $time, when);
            errors++;
        end
    endtask

    task automatic checkResult(input vector_t v, input int idx, input int cycles,
                               input logic sawBusy);
        int   expCycles;
        logic expBusy;
        expCycles = (v.kind == KIND_MISS) ? MissCycles : 1;
        expBusy   = (v.kind == KIND_MISS);
        checks++;
        if (v.kind == KIND_STORE) begin
            if (storeDone !== 1'b1 || readValid !== 1'b0) begin
                $display("FAILED at %0t: vector %0d store gave no clean storeDone", $time, idx);
                errors++;
            end
        end else if (readValid !== 1'b1 || storeDone !== 1'b0) begin
            $display("FAILED at %0t: vector %0d load gave no clean readValid", $time, idx);
            errors++;
        end else if (readData !== v.expData) begin
            $display("FAILED at %0t: vector %0d readData %h, expected %h",
                     $time, idx, readData, v.expData);
            errors++;
        end
        if (cycles != expCycles) begin
            $display("FAILED at %0t: vector %0d took %0d cycles, expected %0d",
                     $time, idx, cycles, expCycles);
            errors++;
        end
        if (sawBusy != expBusy || busy !== 1'b0) begin
            $display("FAILED at %0t: vector %0d busy behaved wrongly", $time, idx);
            errors++;
        end
    endtask

    task automatic runVector(input vector_t v, input int idx);
        int   cycles;
        logic sawBusy;
        logic done;
        while (busy) @(negedge iClk);
        req     = 1'b1;
        reqData = v.req;
        @(negedge iClk);
        req     = 1'b0;
        cycles  = 1;
        sawBusy = 1'b0;
        done    = 1'b0;
        while (!done) begin
            if (busy) sawBusy = 1'b1;
            if (readValid || storeDone) begin
                done = 1'b1;
            end else begin
                @(negedge iClk);
                cycles++;
            end
        end
        checkResult(v, idx, cycles, sawBusy);
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        cycleLimit = 0;
        arstN      = 1'b0;
        req        = 1'b0;
        reqData    = '0;
        readVectors();
        cycleLimit = vectors.size() * (`MEM_LATENCY + 4) + ResetCycles + 50;
        repeat (ResetCycles) begin
            @(negedge iClk);
            checkIdle("during reset");
        end
        arstN = 1'b1;
        @(negedge iClk);
        checkIdle("after reset");
        for (int i = 0; i < vectors.size(); i++) begin
            runVector(vectors[i], i);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Limit comes from the vector count at time zero.
    initial begin
        cycleCount = 0;
        @(posedge iClk);
        while (cycleCount < cycleLimit) begin
            @(posedge iClk);
            cycleCount++;
        end
        $display("The run timed out after %0d clock cycles.", cycleCount);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- dv/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int HalfPeriod = 50 // 100 ns period.
) (
    output logic iClk
);
    initial begin
        iClk = 1'b0;
    end

    always #HalfPeriod iClk = ~iClk;

endmodule

//--- src/dataMemorySubsystem.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dataMemorySubsystem
    import memOpPkg::*;
(
    input  logic                   iClk,
    input  logic                   arstN,
    input  logic                   req,
    input  memReq_t                reqData,
    output logic                   busy,
    output logic                   readValid,
    output logic [`DATA_WIDTH-1:0] readData,
    output logic                   storeDone
);
    localparam int MemAw = $clog2(`MEM_WORDS);

    logic [`INDEX_BITS-1:0] lookupIndex;
    logic [`TAG_BITS-1:0]   lookupTag;
    logic                   fillEn;
    logic [`DATA_WIDTH-1:0] fillData;
    logic                   invalEn;
    logic                   hit;
    logic [`DATA_WIDTH-1:0] hitData;
    logic                   memRead;
    logic                   memWrite;
    logic [MemAw-1:0]       memAddr;
    logic                   memRdValid;
    logic [`DATA_WIDTH-1:0] memRdData;
    logic [3:0]             byteEn;
    logic [`DATA_WIDTH-1:0] laneData;
    logic [`DATA_WIDTH-1:0] alignWord;
    memReq_t                curReq;

    cacheController u_cacheController (
        .iClk(iClk), .arstN(arstN), .req(req), .reqData(reqData),
        .hit(hit), .hitData(hitData), .memRdValid(memRdValid), .memRdData(memRdData),
        .lookupIndex(lookupIndex), .lookupTag(lookupTag), .fillEn(fillEn),
        .fillData(fillData), .invalEn(invalEn), .memRead(memRead), .memWrite(memWrite),
        .memAddr(memAddr), .alignWord(alignWord), .curReq(curReq), .busy(busy),
        .readValid(readValid), .storeDone(storeDone)
    );

    cacheArray u_cacheArray (
        .iClk(iClk), .arstN(arstN), .lookupIndex(lookupIndex), .lookupTag(lookupTag),
        .fillEn(fillEn), .fillData(fillData), .invalEn(invalEn),
        .hit(hit), .hitData(hitData)
    );

    backingMemory u_backingMemory (
        .iClk(iClk), .arstN(arstN), .memRead(memRead), .memWrite(memWrite),
        .memAddr(memAddr), .byteEn(byteEn), .laneData(laneData),
        .memRdValid(memRdValid), .memRdData(memRdData)
    );

    loadAligner u_loadAligner (
        .alignWord(alignWord), .op(curReq.op), .offset(curReq.addr[1:0]),
        .readData(readData)
    );

    storeMerge u_storeMerge (.curReq(curReq), .byteEn(byteEn), .laneData(laneData));

endmodule

//--- src/cacheController.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module cacheController
    import memOpPkg::*, cacheTypesPkg::*;
(
    input  logic                   iClk,
    input  logic                   arstN,
    input  logic                   req,
    input  memReq_t                reqData,
    input  logic                   hit,
    input  logic [`DATA_WIDTH-1:0] hitData,
    input  logic                   memRdValid,
    input  logic [`DATA_WIDTH-1:0] memRdData,
    output logic [`INDEX_BITS-1:0] lookupIndex,
    output logic [`TAG_BITS-1:0]   lookupTag,
    output logic                   fillEn,
    output logic [`DATA_WIDTH-1:0] fillData,
    output logic                   invalEn,
    output logic                   memRead,
    output logic                   memWrite,
    output logic [$clog2(`MEM_WORDS)-1:0] memAddr,
    output logic [`DATA_WIDTH-1:0] alignWord,
    output memReq_t                curReq,
    output logic                   busy,
    output logic                   readValid,
    output logic                   storeDone
);
    ctrlState_e  state;
    ctrlState_e  nextState;
    addrFields_t fields;
    logic        accept;
    logic        storeOp;
    logic        missNow;

    assign fields  = curReq.addr;
    assign storeOp = isStore(curReq.op);
    assign missNow = (state == RESPOND) && !storeOp && !hit; // Lookup of captured load failed.

    assign lookupIndex = fields.index;
    assign lookupTag   = fields.tag;
    assign memAddr     = curReq.addr[$clog2(`MEM_WORDS)+1:2];

    assign busy   = missNow || (state == MISS_WAIT);
    assign accept = req && !busy;

    // Single-cycle strobes decoded from the state.
    assign memRead   = missNow;
    assign memWrite  = (state == RESPOND) && storeOp;
    assign invalEn   = memWrite;   // Write-through drops the indexed line.
    assign storeDone = memWrite;
    assign readValid = (state == RESPOND) && !storeOp && hit;

    assign fillEn    = (state == MISS_WAIT) && memRdValid;
    assign fillData  = memRdData;
    assign alignWord = hitData; // Filled line is read back in RESPOND.

    always_ff @(posedge iClk) begin
        if (accept) begin
            curReq <= reqData;
        end
    end

    always_ff @(posedge iClk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // A filled line is looked up again in RESPOND and reports a hit.
    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (accept) nextState = RESPOND;
            end
            RESPOND: begin
                if (missNow) nextState = MISS_WAIT;
                else if (accept) nextState = RESPOND; // Back-to-back request.
                else nextState = IDLE;
            end
            MISS_WAIT: begin
                if (memRdValid) nextState = RESPOND;
            end
            default: nextState = IDLE;
        endcase
    end

    reqNotBusy: assert property (@(posedge iClk) disable iff (!arstN) req |-> !busy)
        else $error("Request issued while busy.");

    rdOnlyInMiss: assert property (@(posedge iClk) disable iff (!arstN)
        memRdValid |-> state == MISS_WAIT)
        else $error("Memory read data outside a miss.");

    missLatency: assert property (@(posedge iClk) disable iff (!arstN)
        memRead |-> ##(`MEM_LATENCY + 1) readValid)
        else $error("Miss did not return its load data on time.");

endmodule

//--- src/cacheArray.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module cacheArray
    import cacheTypesPkg::*;
(
    input  logic                   iClk,
    input  logic                   arstN,
    input  logic [`INDEX_BITS-1:0] lookupIndex,
    input  logic [`TAG_BITS-1:0]   lookupTag,
    input  logic                   fillEn,
    input  logic [`DATA_WIDTH-1:0] fillData,
    input  logic                   invalEn,
    output logic                   hit,
    output logic [`DATA_WIDTH-1:0] hitData
);
    localparam int Lines = 1 << `INDEX_BITS;

    cacheLine_t lines [Lines];
    cacheLine_t curLine;

    assign curLine = lines[lookupIndex];
    assign hit     = curLine.valid && (curLine.tag == lookupTag);
    assign hitData = curLine.data;

    always_ff @(posedge iClk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < Lines; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (fillEn) begin
            lines[lookupIndex].valid <= 1'b1;
            lines[lookupIndex].tag   <= lookupTag;
            lines[lookupIndex].data  <= fillData;
        end else if (invalEn) begin
            lines[lookupIndex].valid <= 1'b0;
        end
    end

    fillOrInval: assert property (@(posedge iClk) disable iff (!arstN)
        !(fillEn && invalEn))
        else $error("Fill and invalidate on the same cycle.");

endmodule

//--- src/backingMemory.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module backingMemory (
    input  logic                          iClk,
    input  logic                          arstN,
    input  logic                          memRead,
    input  logic                          memWrite,
    input  logic [$clog2(`MEM_WORDS)-1:0] memAddr,
    input  logic [3:0]                    byteEn,
    input  logic [`DATA_WIDTH-1:0]        laneData,
    output logic                          memRdValid,
    output logic [`DATA_WIDTH-1:0]        memRdData
);
    localparam int Lat = `MEM_LATENCY;

    logic [`DATA_WIDTH-1:0] mem [`MEM_WORDS];
    logic [Lat-1:0]         pipeValid;
    logic [`DATA_WIDTH-1:0] pipeData [Lat];

    initial begin
        for (int w = 0; w < `MEM_WORDS; w++) begin
            mem[w] = '0;
        end
    end

    always_ff @(posedge iClk) begin
        if (memWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) mem[memAddr][8*b +: 8] <= laneData[8*b +: 8];
            end
        end
    end

    // Stage 0 of the read pipeline samples the array.
    always_ff @(posedge iClk or negedge arstN) begin
        if (!arstN) begin
            pipeValid <= '0;
        end else begin
            pipeValid[0] <= memRead;
            for (int s = 1; s < Lat; s++) pipeValid[s] <= pipeValid[s-1];
        end
    end

    always_ff @(posedge iClk) begin
        if (memRead) pipeData[0] <= mem[memAddr];
        for (int s = 1; s < Lat; s++) pipeData[s] <= pipeData[s-1];
    end

    assign memRdValid = pipeValid[Lat-1];
    assign memRdData  = pipeData[Lat-1];

    rdWrExcl: assert property (@(posedge iClk) disable iff (!arstN) !(memRead && memWrite))
        else $error("Memory read and write on the same cycle.");

endmodule

//--- src/loadAligner.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module loadAligner
    import memOpPkg::*;
(
    input  logic [`DATA_WIDTH-1:0] alignWord,
    input  memOp_e                 op,
    input  logic [1:0]             offset,
    output logic [`DATA_WIDTH-1:0] readData
);
    logic [7:0]  selByte;
    logic [15:0] selHalf;

    assign selByte = alignWord[8*offset +: 8];

    // Offset 3 falls back to the upper half.
    always_comb begin
        case (offset)
            2'd0:    selHalf = alignWord[15:0];
            2'd1:    selHalf = alignWord[23:8];
            default: selHalf = alignWord[31:16];
        endcase
    end

    always_comb begin
        case (op)
            LOAD_BYTE: begin
                readData = {{(`DATA_WIDTH-8){selByte[7]}}, selByte};
            end
            ULOAD_BYTE: begin
                readData = {{(`DATA_WIDTH-8){1'b0}}, selByte};
            end
            LOAD_HALF: begin
                readData = {{(`DATA_WIDTH-16){selHalf[15]}}, selHalf};
            end
            ULOAD_HALF: begin
                readData = {{(`DATA_WIDTH-16){1'b0}}, selHalf};
            end
            default: readData = alignWord; // Word loads.
        endcase
    end

endmodule

//--- src/storeMerge.sv
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module storeMerge
    import memOpPkg::*;
(
    input  memReq_t                curReq,
    output logic [3:0]             byteEn,
    output logic [`DATA_WIDTH-1:0] laneData
);
    logic [1:0]  offset;
    logic [15:0] half;

    assign offset = curReq.addr[1:0];
    assign half   = curReq.wdata[15:0];

    always_comb begin
        byteEn   = 4'b0000;
        laneData = curReq.wdata;
        case (curReq.op)
            STORE_BYTE: begin
                byteEn[offset] = 1'b1;
                laneData       = {4{curReq.wdata[7:0]}}; // Byte on every lane.
            end
            STORE_HALF: begin
                case (offset)
                    2'd0:    byteEn = 4'b0011;
                    2'd1:    byteEn = 4'b0110;
                    default: byteEn = 4'b1100;
                endcase
                // Half rotated so lanes 2-1 line up for offset 1.
                laneData = (offset == 2'd1) ? {half[7:0], half, half[15:8]} : {2{half}};
            end
            STORE_WORD: byteEn = 4'b1111;
            default:    byteEn = 4'b0000;
        endcase
    end

endmodule

//--- src/cacheTypesPkg.sv
`include "dcache_cfg.svh"

package cacheTypesPkg;

    // Byte address split for the direct-mapped lookup.
    typedef struct packed {
        logic [`TAG_BITS-1:0]                           tag;
        logic [`INDEX_BITS-1:0]                         index;
        logic [`ADDR_WIDTH-`TAG_BITS-`INDEX_BITS-1:0]   offset;
    } addrFields_t;

    typedef struct packed {
        logic                   valid;
        logic [`TAG_BITS-1:0]   tag;
        logic [`DATA_WIDTH-1:0] data;
    } cacheLine_t;

    // Stores and hits finish in RESPOND while misses detour through MISS_WAIT.
    typedef enum logic [1:0] {
        IDLE,
        MISS_WAIT,
        RESPOND
    } ctrlState_e;

endpackage

//--- src/memOpPkg.sv
`include "dcache_cfg.svh"

package memOpPkg;

    typedef enum logic [2:0] {
        LOAD_BYTE,
        LOAD_HALF,
        LOAD_WORD,
        ULOAD_BYTE,
        ULOAD_HALF,
        STORE_BYTE,
        STORE_HALF,
        STORE_WORD
    } memOp_e;

    // One load or store request.
    typedef struct packed {
        memOp_e                 op;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata; // Ignored by loads.
    } memReq_t;

    function automatic logic isStore(memOp_e op);
        return op inside {STORE_BYTE, STORE_HALF, STORE_WORD};
    endfunction

endpackage

//--- include/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Datapath widths.
`define DATA_WIDTH 32
`define ADDR_WIDTH 32

// Direct-mapped cache geometry with one word per line.
`define INDEX_BITS 4
`define TAG_BITS 26

`define MEM_WORDS 1024
`define MEM_LATENCY 3 // Cycles from read issue to data.

`endif
